// File: source/link_pkg.sv
package link_pkg;

  // ====================
  // spi frame layouts
  // ====================

  // bits per spi frame, both directions
  localparam int FRAME_BITS = 19;

  // host to minion, msb first on mosi
  typedef struct packed {
    logic        cmd_valid;  // 0 means poll only
    logic [1:0]  addr;
    logic [15:0] data;
  } cmd_frame_t;

  // minion to host, msb first on miso
  typedef struct packed {
    logic        rsp_valid;
    logic        src;        // 0 loopback, 1 output crossbar
    logic        pad;
    logic [15:0] data;
  } rsp_frame_t;

  // ====================
  // address map
  // ====================

  localparam logic [1:0] ADDR_IN_XBAR  = 2'd0;
  localparam logic [1:0] ADDR_OUT_XBAR = 2'd1;
  localparam logic [1:0] ADDR_IN_CTRL  = 2'd2;
  localparam logic [1:0] ADDR_OUT_CTRL = 2'd3;

  // crossbar control word, carried in the data field
  typedef struct packed {
    logic [7:0] unused;
    logic [3:0] in_sel;
    logic [3:0] out_sel;
  } xbar_ctrl_t;

endpackage

// File: source/accel_pkg.sv
package accel_pkg;

  // ====================
  // accelerator samples
  // ====================

  // one unsigned sample
  // vectors are word_t [N_SAMPLES-1:0], declared where used
  // sums wrap at 2^16
  typedef logic [15:0] word_t;

endpackage

// File: source/spi_minion.sv
`timescale 1ns/1ps

module spi_minion #(
  parameter int SYNC_STAGES = 2
) (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 cs,
  input  logic                 sclk,
  input  logic                 mosi,
  output logic                 miso,
  output link_pkg::cmd_frame_t cmd,
  output logic                 cmd_val,
  input  logic                 cmd_rdy,
  input  link_pkg::rsp_frame_t rsp,
  input  logic                 rsp_val,
  output logic                 rsp_rdy,
  output logic                 minion_parity
);

  localparam int FB = link_pkg::FRAME_BITS;

  // ====================
  // pin synchronizers
  // ====================

  logic [SYNC_STAGES-1:0] cs_sync;
  logic [SYNC_STAGES-1:0] sclk_sync;
  logic [SYNC_STAGES-1:0] mosi_sync;
  logic                   cs_q;
  logic                   sclk_q;
  logic                   cs_s;
  logic                   sclk_s;
  logic                   mosi_s;

  // cs idles high, active low
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cs_sync   <= '1;
      sclk_sync <= '0;
      mosi_sync <= '0;
      cs_q      <= 1'b1;
      sclk_q    <= 1'b0;
    end else begin
      cs_sync   <= {cs_sync[SYNC_STAGES-2:0], cs};
      sclk_sync <= {sclk_sync[SYNC_STAGES-2:0], sclk};
      mosi_sync <= {mosi_sync[SYNC_STAGES-2:0], mosi};
      cs_q      <= cs_s;
      sclk_q    <= sclk_s;
    end
  end

  assign cs_s   = cs_sync[SYNC_STAGES-1];
  assign sclk_s = sclk_sync[SYNC_STAGES-1];
  assign mosi_s = mosi_sync[SYNC_STAGES-1];

  // edges in the clk domain
  logic frame_start;
  logic frame_done;
  logic sclk_rise;
  logic sclk_fall;

  assign frame_start = cs_q && !cs_s;
  assign frame_done  = !cs_q && cs_s;
  assign sclk_rise   = !cs_s && sclk_s && !sclk_q;
  assign sclk_fall   = !cs_s && !sclk_s && sclk_q;

  // ====================
  // shift registers
  // ====================

  logic [FB-1:0]        rx_shift;
  logic [FB-1:0]        tx_shift;
  link_pkg::cmd_frame_t rx_frame;
  link_pkg::rsp_frame_t rsp_hold;
  logic                 rsp_full;

  assign rx_frame = rx_shift;
  assign miso     = tx_shift[FB-1];
  assign rsp_rdy  = !rsp_full;

  // mosi in on rising sclk, msb first
  always_ff @(posedge clk) begin
    if (sclk_rise) begin
      rx_shift <= {rx_shift[FB-2:0], mosi_s};
    end
  end

  // miso out on falling sclk
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      tx_shift <= '0;
    end else if (frame_start) begin
      tx_shift <= rsp_full ? rsp_hold : '0;
    end else if (sclk_fall) begin
      tx_shift <= {tx_shift[FB-2:0], 1'b0};
    end
  end

  // ====================
  // command and reply
  // ====================

  // latched at frame end, polls are dropped
  always_ff @(posedge clk) begin
    if (frame_done && rx_frame.cmd_valid) begin
      cmd <= rx_frame;
    end
    if (rsp_val && rsp_rdy) begin
      rsp_hold <= rsp;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cmd_val       <= 1'b0;
      rsp_full      <= 1'b0;
      minion_parity <= 1'b0;
    end else begin
      // transfer first, a new frame may set it again
      if (cmd_val && cmd_rdy) begin
        cmd_val <= 1'b0;
      end
      if (frame_done && rx_frame.cmd_valid) begin
        cmd_val <= 1'b1;
      end
      if (frame_done) begin
        minion_parity <= ^rx_shift;
      end
      // held reply goes out with the next frame
      if (frame_start) begin
        rsp_full <= 1'b0;
      end
      if (rsp_val && rsp_rdy) begin
        rsp_full <= 1'b1;
      end
    end
  end

  // host keeps frames apart until the pending command is taken
  assert property (@(posedge clk) disable iff (!rst_n)
    (frame_done && rx_frame.cmd_valid) |-> (!cmd_val || cmd_rdy));

endmodule

// File: source/addr_router.sv
`timescale 1ns/1ps

module addr_router (
  input  link_pkg::cmd_frame_t cmd,
  input  logic                 cmd_val,
  output logic                 cmd_rdy,
  output logic [3:0][15:0]     out_data,
  output logic [3:0]           out_val,
  input  logic [3:0]           out_rdy
);

  // ====================
  // address decode
  // ====================

  always_comb begin
    cmd_rdy = 1'b0;
    for (int i = 0; i < 4; i++) begin
      // data fans out to every port
      out_data[i] = cmd.data;
      // valid only at the addressed port
      out_val[i]  = cmd_val && (cmd.addr == 2'(i));
      // ready comes back from the addressed port only
      if (cmd.addr == 2'(i)) begin
        cmd_rdy = out_rdy[i];
      end
    end
  end

endmodule

// File: source/rr_arbiter.sv
`timescale 1ns/1ps

module rr_arbiter (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic [1:0][15:0]     in_data,
  input  logic [1:0]           in_val,
  output logic [1:0]           in_rdy,
  output link_pkg::rsp_frame_t rsp,
  output logic                 rsp_val,
  input  logic                 rsp_rdy
);

  logic       prio;     // input that wins a tie
  logic       gnt_idx;
  logic [1:0] gnt;

  // ====================
  // grant
  // ====================

  always_comb begin
    gnt_idx = in_val[prio] ? prio : !prio;
    gnt     = in_val & (2'b01 << gnt_idx);
  end

  assign rsp_val = |in_val;
  assign in_rdy  = gnt & {2{rsp_rdy}};

  // reply tagged with its source
  always_comb begin
    rsp.rsp_valid = 1'b1;
    rsp.src       = gnt_idx;
    rsp.pad       = 1'b0;
    rsp.data      = in_data[gnt_idx];
  end

  // pointer moves past the winner on each transfer
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      prio <= 1'b0;
    end else if (rsp_val && rsp_rdy) begin
      prio <= !gnt_idx;
    end
  end

  // waiting sources hold their words until taken
  assert property (@(posedge clk) disable iff (!rst_n)
    (in_val[0] && !in_rdy[0]) |=> (in_val[0] && $stable(in_data[0])));
  assert property (@(posedge clk) disable iff (!rst_n)
    (in_val[1] && !in_rdy[1]) |=> (in_val[1] && $stable(in_data[1])));

endmodule

// File: source/blocking_xbar.sv
`timescale 1ns/1ps

module blocking_xbar #(
  parameter int N_INPUTS  = 2,
  parameter int N_OUTPUTS = 2
) (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic [N_INPUTS-1:0][15:0]     in_data,
  input  logic [N_INPUTS-1:0]           in_val,
  output logic [N_INPUTS-1:0]           in_rdy,
  output logic [N_OUTPUTS-1:0][15:0]    out_data,
  output logic [N_OUTPUTS-1:0]          out_val,
  input  logic [N_OUTPUTS-1:0]          out_rdy,
  input  link_pkg::xbar_ctrl_t          ctrl,
  input  logic                          ctrl_val
);

  link_pkg::xbar_ctrl_t ctrl_q;
  logic [15:0]          sel_data;
  logic                 sel_val;
  logic                 sel_rdy;

  // reset value joins input 0 to output 0
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ctrl_q <= '0;
    end else if (ctrl_val) begin
      ctrl_q <= ctrl;
    end
  end

  // ====================
  // single path
  // ====================

  always_comb begin
    sel_data = '0;
    sel_val  = 1'b0;
    sel_rdy  = 1'b0;
    // out of range selects leave both sides stalled
    for (int i = 0; i < N_INPUTS; i++) begin
      if (ctrl_q.in_sel == 4'(i)) begin
        sel_data = in_data[i];
        sel_val  = in_val[i];
      end
    end
    for (int o = 0; o < N_OUTPUTS; o++) begin
      if (ctrl_q.out_sel == 4'(o)) begin
        sel_rdy = out_rdy[o];
      end
    end
    for (int i = 0; i < N_INPUTS; i++) begin
      in_rdy[i] = (ctrl_q.in_sel == 4'(i)) && sel_rdy;
    end
    for (int o = 0; o < N_OUTPUTS; o++) begin
      out_data[o] = sel_data;
      out_val[o]  = (ctrl_q.out_sel == 4'(o)) && sel_val;
    end
  end

  // a stalled output keeps its word until taken
  for (genvar o = 0; o < N_OUTPUTS; o++) begin : g_out_hold
    assert property (@(posedge clk) disable iff (!rst_n)
      (out_val[o] && !out_rdy[o]) |=> (out_val[o] && $stable(out_data[o])));
  end

endmodule

// File: source/vec_deserializer.sv
`timescale 1ns/1ps

module vec_deserializer #(
  parameter int N_SAMPLES = 4
) (
  input  logic                                  clk,
  input  logic                                  rst_n,
  input  accel_pkg::word_t                      in_word,
  input  logic                                  in_val,
  output logic                                  in_rdy,
  output accel_pkg::word_t [N_SAMPLES-1:0]      vec,
  output logic                                  vec_val,
  input  logic                                  vec_rdy
);

  localparam int CNT_W = (N_SAMPLES > 1) ? $clog2(N_SAMPLES) : 1;

  logic [CNT_W-1:0] cnt;
  logic             full;

  assign in_rdy  = !full;
  assign vec_val = full;

  // slots fill in arrival order
  always_ff @(posedge clk) begin
    if (in_val && in_rdy) begin
      vec[cnt] <= in_word;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cnt  <= '0;
      full <= 1'b0;
    end else begin
      if (in_val && in_rdy) begin
        if (cnt == CNT_W'(N_SAMPLES - 1)) begin
          cnt  <= '0;
          full <= 1'b1;
        end else begin
          cnt <= cnt + 1'b1;
        end
      end
      if (vec_val && vec_rdy) begin
        full <= 1'b0;
      end
    end
  end

  // upstream holds its word while the vector waits
  assert property (@(posedge clk) disable iff (!rst_n)
    (in_val && !in_rdy) |=> (in_val && $stable(in_word)));

endmodule

// File: source/vec_serializer.sv
`timescale 1ns/1ps

module vec_serializer #(
  parameter int N_SAMPLES = 4
) (
  input  logic                             clk,
  input  logic                             rst_n,
  input  accel_pkg::word_t [N_SAMPLES-1:0] vec,
  input  logic                             vec_val,
  output logic                             vec_rdy,
  output accel_pkg::word_t                 out_word,
  output logic                             out_val,
  input  logic                             out_rdy
);

  localparam int CNT_W = (N_SAMPLES > 1) ? $clog2(N_SAMPLES) : 1;

  accel_pkg::word_t [N_SAMPLES-1:0] vec_q;
  logic [CNT_W-1:0]                 idx;
  logic                             busy;

  assign vec_rdy  = !busy;
  assign out_val  = busy;
  assign out_word = vec_q[idx];  // element 0 first

  always_ff @(posedge clk) begin
    if (vec_val && vec_rdy) begin
      vec_q <= vec;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      idx  <= '0;
      busy <= 1'b0;
    end else if (vec_val && vec_rdy) begin
      idx  <= '0;
      busy <= 1'b1;
    end else if (out_val && out_rdy) begin
      // last word frees the buffer
      if (idx == CNT_W'(N_SAMPLES - 1)) begin
        busy <= 1'b0;
      end else begin
        idx <= idx + 1'b1;
      end
    end
  end

endmodule

// File: source/prefix_sum_engine.sv
`timescale 1ns/1ps

module prefix_sum_engine #(
  parameter int N_SAMPLES = 4
) (
  input  logic                             clk,
  input  logic                             rst_n,
  input  accel_pkg::word_t [N_SAMPLES-1:0] in_vec,
  input  logic                             in_val,
  output logic                             in_rdy,
  output accel_pkg::word_t [N_SAMPLES-1:0] out_vec,
  output logic                             out_val,
  input  logic                             out_rdy
);

  accel_pkg::word_t [N_SAMPLES-1:0] sums;

  // running sum, wraps at 16 bits
  always_comb begin
    accel_pkg::word_t acc;
    acc = '0;
    for (int i = 0; i < N_SAMPLES; i++) begin
      acc     = acc + in_vec[i];
      sums[i] = acc;
    end
  end

  // empty or draining this cycle
  assign in_rdy = !out_val || out_rdy;

  always_ff @(posedge clk) begin
    if (in_val && in_rdy) begin
      out_vec <= sums;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      out_val <= 1'b0;
    end else if (in_val && in_rdy) begin
      out_val <= 1'b1;
    end else if (out_rdy) begin
      out_val <= 1'b0;
    end
  end

endmodule

// File: source/spi_interconnect.sv
`timescale 1ns/1ps

module spi_interconnect #(
  parameter int N_SAMPLES = 4
) (
  input  logic clk,
  input  logic rst_n,
  input  logic cs,
  input  logic sclk,
  input  logic mosi,
  output logic miso,
  output logic minion_parity
);

  localparam int SYNC_STAGES = 2;

  // ====================
  // spi side
  // ====================

  link_pkg::cmd_frame_t cmd;
  logic                 cmd_val;
  logic                 cmd_rdy;
  link_pkg::rsp_frame_t rsp;
  logic                 rsp_val;
  logic                 rsp_rdy;

  spi_minion #(
    .SYNC_STAGES(SYNC_STAGES)
  ) minion_inst (
    .clk(clk),
    .rst_n(rst_n),
    .cs(cs),
    .sclk(sclk),
    .mosi(mosi),
    .miso(miso),
    .cmd(cmd),
    .cmd_val(cmd_val),
    .cmd_rdy(cmd_rdy),
    .rsp(rsp),
    .rsp_val(rsp_val),
    .rsp_rdy(rsp_rdy),
    .minion_parity(minion_parity)
  );

  logic [3:0][15:0] rt_data;
  logic [3:0]       rt_val;
  logic [3:0]       rt_rdy;

  addr_router router_inst (
    .cmd(cmd),
    .cmd_val(cmd_val),
    .cmd_rdy(cmd_rdy),
    .out_data(rt_data),
    .out_val(rt_val),
    .out_rdy(rt_rdy)
  );

  // ====================
  // crossbars
  // ====================

  logic [0:0]       ixb_in_rdy;
  logic [1:0][15:0] ixb_out_data;
  logic [1:0]       ixb_out_val;
  logic [1:0]       ixb_out_rdy;
  logic [1:0]       oxb_in_rdy;
  logic [0:0][15:0] oxb_out_data;
  logic [0:0]       oxb_out_val;
  logic [0:0]       oxb_out_rdy;

  // control writes always land
  assign rt_rdy[link_pkg::ADDR_IN_XBAR]  = ixb_in_rdy[0];
  assign rt_rdy[link_pkg::ADDR_OUT_XBAR] = oxb_in_rdy[0];
  assign rt_rdy[link_pkg::ADDR_IN_CTRL]  = 1'b1;
  assign rt_rdy[link_pkg::ADDR_OUT_CTRL] = 1'b1;

  // output 0 loopback, output 1 accelerator
  blocking_xbar #(
    .N_INPUTS(1),
    .N_OUTPUTS(2)
  ) in_xbar (
    .clk(clk),
    .rst_n(rst_n),
    .in_data(rt_data[link_pkg::ADDR_IN_XBAR]),
    .in_val(rt_val[link_pkg::ADDR_IN_XBAR]),
    .in_rdy(ixb_in_rdy),
    .out_data(ixb_out_data),
    .out_val(ixb_out_val),
    .out_rdy(ixb_out_rdy),
    .ctrl(link_pkg::xbar_ctrl_t'(rt_data[link_pkg::ADDR_IN_CTRL])),
    .ctrl_val(rt_val[link_pkg::ADDR_IN_CTRL])
  );

  // ====================
  // accelerator
  // ====================

  accel_pkg::word_t [N_SAMPLES-1:0] des_vec;
  logic                             des_vec_val;
  logic                             des_vec_rdy;
  accel_pkg::word_t [N_SAMPLES-1:0] psum_vec;
  logic                             psum_val;
  logic                             psum_rdy;
  accel_pkg::word_t                 ser_word;
  logic                             ser_val;

  vec_deserializer #(
    .N_SAMPLES(N_SAMPLES)
  ) deser_inst (
    .clk(clk),
    .rst_n(rst_n),
    .in_word(ixb_out_data[1]),
    .in_val(ixb_out_val[1]),
    .in_rdy(ixb_out_rdy[1]),
    .vec(des_vec),
    .vec_val(des_vec_val),
    .vec_rdy(des_vec_rdy)
  );

  prefix_sum_engine #(
    .N_SAMPLES(N_SAMPLES)
  ) psum_inst (
    .clk(clk),
    .rst_n(rst_n),
    .in_vec(des_vec),
    .in_val(des_vec_val),
    .in_rdy(des_vec_rdy),
    .out_vec(psum_vec),
    .out_val(psum_val),
    .out_rdy(psum_rdy)
  );

  vec_serializer #(
    .N_SAMPLES(N_SAMPLES)
  ) ser_inst (
    .clk(clk),
    .rst_n(rst_n),
    .vec(psum_vec),
    .vec_val(psum_val),
    .vec_rdy(psum_rdy),
    .out_word(ser_word),
    .out_val(ser_val),
    .out_rdy(oxb_in_rdy[1])
  );

  // input 0 host words, input 1 accelerator results
  blocking_xbar #(
    .N_INPUTS(2),
    .N_OUTPUTS(1)
  ) out_xbar (
    .clk(clk),
    .rst_n(rst_n),
    .in_data({ser_word, rt_data[link_pkg::ADDR_OUT_XBAR]}),
    .in_val({ser_val, rt_val[link_pkg::ADDR_OUT_XBAR]}),
    .in_rdy(oxb_in_rdy),
    .out_data(oxb_out_data),
    .out_val(oxb_out_val),
    .out_rdy(oxb_out_rdy),
    .ctrl(link_pkg::xbar_ctrl_t'(rt_data[link_pkg::ADDR_OUT_CTRL])),
    .ctrl_val(rt_val[link_pkg::ADDR_OUT_CTRL])
  );

  // ====================
  // reply merge
  // ====================

  logic [1:0] arb_in_rdy;

  assign ixb_out_rdy[0] = arb_in_rdy[0];
  assign oxb_out_rdy[0] = arb_in_rdy[1];

  // src 0 loopback, src 1 output crossbar
  rr_arbiter arb_inst (
    .clk(clk),
    .rst_n(rst_n),
    .in_data({oxb_out_data[0], ixb_out_data[0]}),
    .in_val({oxb_out_val[0], ixb_out_val[0]}),
    .in_rdy(arb_in_rdy),
    .rsp(rsp),
    .rsp_val(rsp_val),
    .rsp_rdy(rsp_rdy)
  );

endmodule

// File: bench/spi_host.svh
`ifndef SPI_HOST_SVH
`define SPI_HOST_SVH

// ====================
// spi host side
// ====================

// one full frame, mosi out and miso in, msb first
// cs leads and trails by one sclk half period
task automatic send_frame(
  input  link_pkg::cmd_frame_t tx,
  output link_pkg::rsp_frame_t rx
);
  logic [link_pkg::FRAME_BITS-1:0] tx_bits;
  logic [link_pkg::FRAME_BITS-1:0] rx_bits;
  tx_bits = tx;
  rx_bits = '0;
  @(posedge clk);
  cs   <= 1'b0;
  sclk <= 1'b0;
  // room for the minion to load its reply
  repeat (SCLK_HALF) @(posedge clk);
  for (int i = link_pkg::FRAME_BITS - 1; i >= 0; i--) begin
    mosi <= tx_bits[i];
    repeat (SCLK_HALF - 1) @(posedge clk);
    // miso settled well before the rising sclk
    @(negedge clk);
    rx_bits[i] = miso;
    @(posedge clk);
    sclk <= 1'b1;
    repeat (SCLK_HALF) @(posedge clk);
    sclk <= 1'b0;
  end
  repeat (SCLK_HALF) @(posedge clk);
  cs <= 1'b1;
  // gap lets the command leave the minion before the next frame
  repeat (FRAME_GAP) @(posedge clk);
  rx = rx_bits;
  compare_bit("minion_parity", minion_parity, ^tx_bits);
endtask

// empty frames until a reply shows up, or the limit runs out
task automatic poll_reply(
  output link_pkg::rsp_frame_t rx,
  output logic                 found
);
  link_pkg::cmd_frame_t poll;
  int                   n;
  poll  = '0;
  rx    = '0;
  found = 1'b0;
  n     = 0;
  while (!found && n < POLL_LIMIT) begin
    send_frame(poll, rx);
    found = rx.rsp_valid;
    n++;
  end
endtask

`endif

// File: bench/spi_interconnect_tb.sv
`timescale 1ns/1ps

module spi_interconnect_tb;

  localparam int N_SAMPLES  = 4;
  localparam int CLK_PERIOD = 4;
  localparam int SCLK_HALF  = 4;   // clk cycles per sclk half period
  localparam int FRAME_GAP  = 8;
  localparam int POLL_LIMIT = 8;
  // idle, loopback, pass-through, 2 config, samples, 2 restore, loopback, idle
  localparam int N_STEPS    = N_SAMPLES + 9;

  localparam int FRAME_CYCLES = SCLK_HALF * (2 * link_pkg::FRAME_BITS + 2) + FRAME_GAP + 1;
  localparam int FRAME_NS     = FRAME_CYCLES * CLK_PERIOD;
  localparam int WATCHDOG_NS  = N_STEPS * (POLL_LIMIT + 1) * FRAME_NS * 2;

  logic clk;
  logic rst_n;
  logic cs;
  logic sclk;
  logic mosi;
  logic miso;
  logic minion_parity;

  // one table row, replies kept apart in exp_rsp
  typedef struct packed {
    link_pkg::cmd_frame_t cmd;
    logic [7:0]           n_rsp;
    logic                 idle_chk;  // frame's own reply must be empty
  } step_t;

  step_t                steps [N_STEPS];
  link_pkg::rsp_frame_t exp_rsp [N_STEPS][N_SAMPLES];
  int                   n_steps;
  integer               seed;
  int                   check_cnt;
  int                   mismatch_cnt;
  int                   missing_cnt;

  spi_interconnect #(
    .N_SAMPLES(N_SAMPLES)
  ) spi_interconnect_inst (
    .clk(clk),
    .rst_n(rst_n),
    .cs(cs),
    .sclk(sclk),
    .mosi(mosi),
    .miso(miso),
    .minion_parity(minion_parity)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  `include "spi_host.svh"

  // ====================
  // compare tasks
  // ====================

  // src and data only, rsp_valid is checked by the poll
  task automatic verify_reply(
    input string                name,
    input link_pkg::rsp_frame_t got,
    input link_pkg::rsp_frame_t want
  );
    check_cnt++;
    if (got.src !== want.src || got.data !== want.data) begin
      mismatch_cnt++;
      $display("FAILED t=%0t %s got src=%0b data=%h expected src=%0b data=%h",
               $time, name, got.src, got.data, want.src, want.data);
    end
  endtask

  task automatic compare_bit(input string name, input logic got, input logic want);
    check_cnt++;
    if (got !== want) begin
      mismatch_cnt++;
      $display("FAILED t=%0t %s got %b expected %b", $time, name, got, want);
    end
  endtask

  // ====================
  // stimulus table
  // ====================

  function automatic link_pkg::cmd_frame_t make_cmd(
    input logic        valid,
    input logic [1:0]  addr,
    input logic [15:0] data
  );
    link_pkg::cmd_frame_t c;
    c.cmd_valid = valid;
    c.addr      = addr;
    c.data      = data;
    return c;
  endfunction

  task automatic add_step(input link_pkg::cmd_frame_t cmd, input int n_rsp, input logic idle);
    steps[n_steps].cmd      = cmd;
    steps[n_steps].n_rsp    = 8'(n_rsp);
    steps[n_steps].idle_chk = idle;
    n_steps++;
  endtask

  task automatic expect_reply(input int s, input int k, input logic src, input logic [15:0] d);
    exp_rsp[s][k].rsp_valid = 1'b1;
    exp_rsp[s][k].src       = src;
    exp_rsp[s][k].pad       = 1'b0;
    exp_rsp[s][k].data      = d;
  endtask

  task automatic build_table();
    accel_pkg::word_t     w;
    accel_pkg::word_t     acc;
    link_pkg::xbar_ctrl_t ctrl;
    int                   last;
    n_steps = 0;
    // nothing pending straight after reset
    add_step(make_cmd(1'b0, 2'd0, 16'h0000), 0, 1'b1);
    // loopback through input crossbar output 0
    w = accel_pkg::word_t'($random(seed));
    expect_reply(n_steps, 0, 1'b0, w);
    add_step(make_cmd(1'b1, link_pkg::ADDR_IN_XBAR, w), 1, 1'b0);
    // host word through output crossbar input 0
    w = accel_pkg::word_t'($random(seed));
    expect_reply(n_steps, 0, 1'b1, w);
    add_step(make_cmd(1'b1, link_pkg::ADDR_OUT_XBAR, w), 1, 1'b0);
    // output crossbar takes accelerator results
    ctrl        = '0;
    ctrl.in_sel = 4'd1;
    add_step(make_cmd(1'b1, link_pkg::ADDR_OUT_CTRL, ctrl), 0, 1'b0);
    // input crossbar feeds the deserializer
    ctrl         = '0;
    ctrl.out_sel = 4'd1;
    add_step(make_cmd(1'b1, link_pkg::ADDR_IN_CTRL, ctrl), 0, 1'b0);
    // all sums come back after the last sample
    acc  = '0;
    last = n_steps + N_SAMPLES - 1;
    for (int i = 0; i < N_SAMPLES; i++) begin
      w   = accel_pkg::word_t'($random(seed));
      acc = acc + w;  // wraps at 2^16
      expect_reply(last, i, 1'b1, acc);
      add_step(make_cmd(1'b1, link_pkg::ADDR_IN_XBAR, w),
               (i == N_SAMPLES - 1) ? N_SAMPLES : 0, 1'b0);
    end
    // back to reset routing
    add_step(make_cmd(1'b1, link_pkg::ADDR_IN_CTRL, 16'h0000), 0, 1'b0);
    add_step(make_cmd(1'b1, link_pkg::ADDR_OUT_CTRL, 16'h0000), 0, 1'b0);
    w = accel_pkg::word_t'($random(seed));
    expect_reply(n_steps, 0, 1'b0, w);
    add_step(make_cmd(1'b1, link_pkg::ADDR_IN_XBAR, w), 1, 1'b0);
    add_step(make_cmd(1'b0, 2'd0, 16'h0000), 0, 1'b1);
  endtask

  task automatic run_table();
    link_pkg::rsp_frame_t rx;
    logic                 found;
    logic                 lost;
    for (int s = 0; s < n_steps; s++) begin
      send_frame(steps[s].cmd, rx);
      if (steps[s].idle_chk) begin
        compare_bit($sformatf("step%0d.rsp_valid", s), rx.rsp_valid, 1'b0);
      end
      lost = 1'b0;
      for (int k = 0; k < int'(steps[s].n_rsp); k++) begin
        if (!lost) begin
          poll_reply(rx, found);
          if (!found) begin
            // stop waiting on the rest of this step
            lost = 1'b1;
            missing_cnt++;
            $display("step %0d: no reply arrived for reply %0d within %0d polls",
                     s, k, POLL_LIMIT);
          end else begin
            verify_reply($sformatf("step%0d.rsp[%0d]", s, k), rx, exp_rsp[s][k]);
          end
        end
      end
    end
  endtask

  // ====================
  // main flow
  // ====================

  initial begin
    clk          = 1'b0;
    rst_n        = 1'b0;
    cs           = 1'b1;
    sclk         = 1'b0;
    mosi         = 1'b0;
    seed         = 32'h1cde_0d9f;
    check_cnt    = 0;
    mismatch_cnt = 0;
    missing_cnt  = 0;
    build_table();
    repeat (2) @(posedge clk);
    rst_n <= 1'b1;
    repeat (4) @(posedge clk);
    run_table();
    $display("checks %0d, mismatches %0d, missing replies %0d",
             check_cnt, mismatch_cnt, missing_cnt);
    if (mismatch_cnt == 0 && missing_cnt == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

  // bound on the whole table with every poll used
  initial begin
    #(WATCHDOG_NS);
    $display("watchdog expired after %0d ns, the table did not complete", WATCHDOG_NS);
    $display(">>> FAIL");
    $finish;
  end

endmodule

// File: build.f
+incdir+bench
source/link_pkg.sv
source/accel_pkg.sv
source/spi_minion.sv
source/addr_router.sv
source/rr_arbiter.sv
source/blocking_xbar.sv
source/vec_deserializer.sv
source/vec_serializer.sv
source/prefix_sum_engine.sv
source/spi_interconnect.sv
bench/spi_interconnect_tb.sv

// File: run.sh
#!/bin/sh
# build and run the spi interconnect testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
  -f build.f --top-module spi_interconnect_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

out=$(./obj_dir/Vspi_interconnect_tb)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -qx '>>> PASS'; then
  exit 0
fi
exit 1
